//--- source/cdb_settings.svh
`ifndef CDB_SETTINGS_SVH
`define CDB_SETTINGS_SVH

// operand, result and tag widths
`define CDB_DATA_W 32
`define CDB_TAG_W 4

// fixed unit latencies in cycles
// mul is the longest and sets the reservation depth
`define CDB_LAT_MUL 8
`define CDB_LAT_ADD 4
`define CDB_LAT_MOV 1

`endif

//--- source/cdb_pkg.sv
`include "cdb_settings.svh"

package cdb_pkg;

	localparam int N_UNITS = 3;

	// UNIT_NONE marks an empty bus slot
	typedef enum logic [1:0] {
		UNIT_MUL = 2'd0,
		UNIT_ADD = 2'd1,
		UNIT_MOV = 2'd2,
		UNIT_NONE = 2'd3
	} unit_t;

	typedef logic [`CDB_TAG_W-1:0] tag_t;
	typedef logic [`CDB_DATA_W-1:0] data_t;

	// one result on its way to the bus
	typedef struct packed {
		logic valid;
		tag_t tag;
		data_t data;
	} beat_t;

endpackage

//--- source/cdb_ifs.sv
`include "cdb_settings.svh"

interface dispatch_if import cdb_pkg::*; ();

	logic pending;
	unit_t unit;
	tag_t tag;
	data_t a;
	data_t b;
	logic fire;

	modport issue (
		output pending, unit, tag, a, b,
		input fire
	);

	modport sched (
		input pending, unit,
		output fire
	);

	modport exec (
		input fire, unit, tag, a, b
	);

endinterface

//--- source/issue_stage.sv
`include "cdb_settings.svh"

module issue_stage import cdb_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic issue_valid,
	input unit_t issue_unit,
	input tag_t issue_tag,
	input data_t issue_a,
	input data_t issue_b,
	output logic issue_ready,
	dispatch_if.issue dsp
);

	logic held_q;
	unit_t unit_q;
	tag_t tag_q;
	data_t a_q;
	data_t b_q;
	logic take;

	// free slot, or the held op leaves this cycle
	assign issue_ready = !held_q || dsp.fire;
	assign take = issue_valid && issue_ready;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			held_q <= 1'b0;
		end else if (take) begin
			held_q <= 1'b1;
		end else if (dsp.fire) begin
			held_q <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			unit_q <= issue_unit;
			tag_q <= issue_tag;
			a_q <= issue_a;
			b_q <= issue_b;
		end
	end

	assign dsp.pending = held_q;
	assign dsp.unit = unit_q;
	assign dsp.tag = tag_q;
	assign dsp.a = a_q;
	assign dsp.b = b_q;

	// a blocked op stays on the inputs unchanged until it is taken
	assert property (@(posedge clk) disable iff (!rst_n)
		issue_valid && !issue_ready |=>
			issue_valid && $stable({issue_unit, issue_tag, issue_a, issue_b}));

endmodule

//--- source/slot_scheduler.sv
`include "cdb_settings.svh"

module slot_scheduler import cdb_pkg::*; (
	input logic clk,
	input logic rst_n,
	dispatch_if.sched dsp,
	output unit_t wb_owner
);

	localparam int DEPTH = `CDB_LAT_MUL;
	localparam int IDX_W = $clog2(DEPTH);
	localparam int LAT_MUL = `CDB_LAT_MUL;
	localparam int LAT_ADD = `CDB_LAT_ADD;
	localparam int LAT_MOV = `CDB_LAT_MOV;

	// slot k owns the bus k cycles from now
	unit_t slot_q [DEPTH];
	unit_t shifted [DEPTH];
	logic [IDX_W-1:0] target;

	////////////////////////////////////////
	// next-cycle view of the slots

	always_comb begin
		for (int k = 0; k < DEPTH - 1; k++) begin
			shifted[k] = slot_q[k + 1];
		end
		shifted[DEPTH-1] = UNIT_NONE;
	end

	always_comb begin
		case (dsp.unit)
			UNIT_MUL: target = IDX_W'(LAT_MUL - 1);
			UNIT_ADD: target = IDX_W'(LAT_ADD - 1);
			default: target = IDX_W'(LAT_MOV - 1);
		endcase
	end

	// mul lands in the top slot, which is always empty after the shift
	assign dsp.fire = dsp.pending && (dsp.unit == UNIT_MUL || shifted[target] == UNIT_NONE);

	////////////////////////////////////////
	// reservation register

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int k = 0; k < DEPTH; k++) begin
				slot_q[k] <= UNIT_NONE;
			end
		end else begin
			for (int k = 0; k < DEPTH; k++) begin
				if (dsp.fire && target == IDX_W'(k)) begin
					slot_q[k] <= dsp.unit;
				end else begin
					slot_q[k] <= shifted[k];
				end
			end
		end
	end

	assign wb_owner = slot_q[0];

	// a claimed slot is never taken over before it reaches the bus
	assert property (@(posedge clk) disable iff (!rst_n)
		dsp.fire && dsp.unit == UNIT_MUL |-> ##LAT_MUL wb_owner == UNIT_MUL);
	assert property (@(posedge clk) disable iff (!rst_n)
		dsp.fire && dsp.unit == UNIT_ADD |-> ##LAT_ADD wb_owner == UNIT_ADD);
	assert property (@(posedge clk) disable iff (!rst_n)
		dsp.fire && dsp.unit == UNIT_MOV |-> ##LAT_MOV wb_owner == UNIT_MOV);

endmodule

//--- source/exec_pipe.sv
module exec_pipe import cdb_pkg::*; #(
	parameter int LATENCY = 1
) (
	input logic clk,
	input logic rst_n,
	input beat_t in_beat,
	output beat_t out_beat
);

	beat_t stage_q [LATENCY];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < LATENCY; i++) begin
				stage_q[i] <= '0;
			end
		end else begin
			stage_q[0] <= in_beat;
			for (int i = 1; i < LATENCY; i++) begin
				stage_q[i] <= stage_q[i - 1];
			end
		end
	end

	// last stage lines up with slot 0 of the scheduler
	assign out_beat = stage_q[LATENCY-1];

endmodule

//--- source/exec_units.sv
`include "cdb_settings.svh"

module exec_units import cdb_pkg::*; (
	input logic clk,
	input logic rst_n,
	dispatch_if.exec dsp,
	output beat_t unit_out [N_UNITS]
);

	data_t product;
	data_t sum;
	beat_t mul_in;
	beat_t add_in;
	beat_t mov_in;

	// low word only, sum wraps
	assign product = dsp.a * dsp.b;
	assign sum = dsp.a + dsp.b;

	always_comb begin
		mul_in.valid = dsp.fire && dsp.unit == UNIT_MUL;
		mul_in.tag = dsp.tag;
		mul_in.data = product;

		add_in.valid = dsp.fire && dsp.unit == UNIT_ADD;
		add_in.tag = dsp.tag;
		add_in.data = sum;

		mov_in.valid = dsp.fire && dsp.unit == UNIT_MOV;
		mov_in.tag = dsp.tag;
		mov_in.data = dsp.a;
	end

	exec_pipe #(.LATENCY(`CDB_LAT_MUL)) u_mul_pipe (
		.clk,
		.rst_n,
		.in_beat(mul_in),
		.out_beat(unit_out[UNIT_MUL])
	);

	exec_pipe #(.LATENCY(`CDB_LAT_ADD)) u_add_pipe (
		.clk,
		.rst_n,
		.in_beat(add_in),
		.out_beat(unit_out[UNIT_ADD])
	);

	exec_pipe #(.LATENCY(`CDB_LAT_MOV)) u_mov_pipe (
		.clk,
		.rst_n,
		.in_beat(mov_in),
		.out_beat(unit_out[UNIT_MOV])
	);

endmodule

//--- source/cdb_mux.sv
`include "cdb_settings.svh"

module cdb_mux import cdb_pkg::*; (
	input logic clk,
	input logic rst_n,
	input unit_t wb_owner,
	input beat_t unit_out [N_UNITS],
	output logic cdb_valid,
	output tag_t cdb_tag,
	output data_t cdb_data
);

	beat_t sel;
	logic [N_UNITS-1:0] beat_valid;

	always_comb begin
		case (wb_owner)
			UNIT_MUL: sel = unit_out[UNIT_MUL];
			UNIT_ADD: sel = unit_out[UNIT_ADD];
			UNIT_MOV: sel = unit_out[UNIT_MOV];
			default: sel = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cdb_valid <= 1'b0;
		end else begin
			cdb_valid <= sel.valid;
		end
	end

	always_ff @(posedge clk) begin
		cdb_tag <= sel.tag;
		cdb_data <= sel.data;
	end

	for (genvar u = 0; u < N_UNITS; u++) begin : g_valid
		assign beat_valid[u] = unit_out[u].valid;
	end

	// owner and pipe outputs agree, so no result is dropped or doubled
	assert property (@(posedge clk) disable iff (!rst_n)
		wb_owner != UNIT_NONE |-> sel.valid && $onehot(beat_valid));
	assert property (@(posedge clk) disable iff (!rst_n)
		wb_owner == UNIT_NONE |-> beat_valid == '0);

endmodule

//--- source/cdb_core.sv
`include "cdb_settings.svh"

module cdb_core import cdb_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic issue_valid,
	input unit_t issue_unit,
	input tag_t issue_tag,
	input data_t issue_a,
	input data_t issue_b,
	output logic issue_ready,
	output logic cdb_valid,
	output tag_t cdb_tag,
	output data_t cdb_data
);

	dispatch_if dsp ();

	unit_t wb_owner;
	beat_t unit_out [N_UNITS];

	issue_stage u_issue (
		.clk,
		.rst_n,
		.issue_valid,
		.issue_unit,
		.issue_tag,
		.issue_a,
		.issue_b,
		.issue_ready,
		.dsp(dsp.issue)
	);

	slot_scheduler u_sched (
		.clk,
		.rst_n,
		.dsp(dsp.sched),
		.wb_owner
	);

	exec_units u_exec (
		.clk,
		.rst_n,
		.dsp(dsp.exec),
		.unit_out
	);

	cdb_mux u_mux (
		.clk,
		.rst_n,
		.wb_owner,
		.unit_out,
		.cdb_valid,
		.cdb_tag,
		.cdb_data
	);

endmodule

//--- tests/tb_cdb_core.sv
`include "cdb_settings.svh"

module tb_cdb_core import cdb_pkg::*; ();

	localparam int N_TAGS = 1 << `CDB_TAG_W;
	localparam int WAIT_LIMIT = 200;
	localparam int N_RANDOM = 60;

	logic clk;
	logic rst_n;
	logic issue_valid;
	unit_t issue_unit;
	tag_t issue_tag;
	data_t issue_a;
	data_t issue_b;
	logic issue_ready;
	logic cdb_valid;
	tag_t cdb_tag;
	data_t cdb_data;

	logic [N_TAGS-1:0] outstanding;
	data_t exp_data [N_TAGS];
	int exp_lat [N_TAGS];
	int xfer_cycle [N_TAGS];
	int cycle;
	logic seen_xfer;
	logic stall_seen;
	logic timing_probe;
	int check_fails = 0;
	int flow_errors = 0;

	cdb_core u_dut (
		.clk,
		.rst_n,
		.issue_valid,
		.issue_unit,
		.issue_tag,
		.issue_a,
		.issue_b,
		.issue_ready,
		.cdb_valid,
		.cdb_tag,
		.cdb_data
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	function automatic data_t unit_result(unit_t unit, data_t a, data_t b);
		case (unit)
			UNIT_MUL: return a * b;
			UNIT_ADD: return a + b;
			default: return a;
		endcase
	endfunction

	// transfer edge to cdb_valid on an idle core
	function automatic int bus_latency(unit_t unit);
		case (unit)
			UNIT_MUL: return `CDB_LAT_MUL + 2;
			UNIT_ADD: return `CDB_LAT_ADD + 2;
			default: return `CDB_LAT_MOV + 2;
		endcase
	endfunction

	////////////////////////////////////////
	// scoreboard

	always @(posedge clk) begin
		if (!rst_n) begin
			outstanding <= '0;
			cycle <= 0;
			seen_xfer <= 1'b0;
			stall_seen <= 1'b0;
			for (int t = 0; t < N_TAGS; t++) begin
				exp_lat[t] <= 0;
			end
		end else begin
			cycle <= cycle + 1;
			if (!issue_ready) begin
				stall_seen <= 1'b1;
			end
			if (cdb_valid) begin
				outstanding[cdb_tag] <= 1'b0;
			end
			if (issue_valid && issue_ready) begin
				seen_xfer <= 1'b1;
				outstanding[issue_tag] <= 1'b1;
				exp_data[issue_tag] <= unit_result(issue_unit, issue_a, issue_b);
				xfer_cycle[issue_tag] <= cycle;
				exp_lat[issue_tag] <= timing_probe ? bus_latency(issue_unit) : 0;
			end
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n) !seen_xfer |-> !cdb_valid)
		else begin
			check_fails++;
			$display("CHECK FAILED t=%0t cdb_valid expected 0 got %b", $time,
				$sampled(cdb_valid));
		end

	assert property (@(posedge clk) disable iff (!rst_n) !seen_xfer |-> issue_ready)
		else begin
			check_fails++;
			$display("CHECK FAILED t=%0t issue_ready expected 1 got %b", $time,
				$sampled(issue_ready));
		end

	assert property (@(posedge clk) disable iff (!rst_n) cdb_valid |-> outstanding[cdb_tag])
		else begin
			check_fails++;
			$display("bus beat at t=%0t has tag %0h with no operation in flight", $time,
				$sampled(cdb_tag));
		end

	assert property (@(posedge clk) disable iff (!rst_n)
		cdb_valid |-> cdb_data == exp_data[cdb_tag])
		else begin
			check_fails++;
			$display("CHECK FAILED t=%0t cdb_data expected %h got %h", $time,
				exp_data[$sampled(cdb_tag)], $sampled(cdb_data));
		end

	assert property (@(posedge clk) disable iff (!rst_n)
		cdb_valid && exp_lat[cdb_tag] != 0 |-> cycle - xfer_cycle[cdb_tag] == exp_lat[cdb_tag])
		else begin
			check_fails++;
			$display("CHECK FAILED t=%0t cdb_valid latency expected %0d got %0d", $time,
				exp_lat[$sampled(cdb_tag)],
				$sampled(cycle) - xfer_cycle[$sampled(cdb_tag)]);
		end

	////////////////////////////////////////
	// stimulus

	// picks a free tag, presents the op and returns just after its transfer edge
	task automatic issue_op(input unit_t unit, input data_t a, input data_t b, input logic probe);
		tag_t tag;
		int start;
		int waited;
		logic found;
		found = 1'b0;
		waited = 0;
		@(negedge clk);
		while (!found && waited < WAIT_LIMIT) begin
			start = $urandom_range(N_TAGS - 1, 0);
			for (int k = 0; k < N_TAGS; k++) begin
				if (!found && !outstanding[tag_t'(start + k)]) begin
					tag = tag_t'(start + k);
					found = 1'b1;
				end
			end
			if (!found) begin
				waited++;
				@(negedge clk);
			end
		end
		if (!found) begin
			flow_errors++;
			$display("timeout at t=%0t: no tag came free for a new operation", $time);
			return;
		end
		@(posedge clk);
		issue_valid <= 1'b1;
		issue_unit <= unit;
		issue_tag <= tag;
		issue_a <= a;
		issue_b <= b;
		timing_probe <= probe;
		waited = 0;
		@(negedge clk);
		while (!issue_ready && waited < WAIT_LIMIT) begin
			waited++;
			@(negedge clk);
		end
		if (!issue_ready) begin
			flow_errors++;
			$display("timeout at t=%0t: issue_ready stayed low", $time);
		end
		@(posedge clk);
		issue_valid <= 1'b0;
		timing_probe <= 1'b0;
	endtask

	task automatic wait_drain();
		int waited;
		waited = 0;
		@(negedge clk);
		while (outstanding != '0 && waited < WAIT_LIMIT) begin
			waited++;
			@(negedge clk);
		end
		assert (outstanding == '0)
			else begin
				flow_errors++;
				$display("timeout at t=%0t: tags %h never reached the bus", $time, outstanding);
			end
		@(posedge clk);
	endtask

	initial begin
		void'($urandom(32'hb3d8da16));
		rst_n <= 1'b0;
		issue_valid <= 1'b0;
		issue_unit <= UNIT_MOV;
		issue_tag <= '0;
		issue_a <= '0;
		issue_b <= '0;
		timing_probe <= 1'b0;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		repeat (4) @(posedge clk);

		// one op at a time into an idle core
		issue_op(UNIT_MUL, $urandom, $urandom, 1'b1);
		wait_drain();
		issue_op(UNIT_ADD, $urandom, $urandom, 1'b1);
		wait_drain();
		issue_op(UNIT_MOV, $urandom, $urandom, 1'b1);
		wait_drain();

		// add lands on the mul's bus slot and has to wait
		issue_op(UNIT_MUL, $urandom, $urandom, 1'b0);
		repeat (2) @(posedge clk);
		issue_op(UNIT_ADD, $urandom, $urandom, 1'b0);
		issue_op(UNIT_MOV, $urandom, $urandom, 1'b0);
		wait_drain();
		assert (stall_seen)
			else begin
				flow_errors++;
				$display("issue_ready never went low during the slot conflict");
			end

		for (int n = 0; n < N_RANDOM; n++) begin
			issue_op(unit_t'(2'($urandom_range(2, 0))), $urandom, $urandom, 1'b0);
			repeat ($urandom_range(2, 0)) @(posedge clk);
		end
		wait_drain();

		$display("check failures: %0d, flow errors: %0d", check_fails, flow_errors);
		if (check_fails == 0 && flow_errors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

//--- project.f
+incdir+source
source/cdb_pkg.sv
source/cdb_ifs.sv
source/issue_stage.sv
source/slot_scheduler.sv
source/exec_pipe.sv
source/exec_units.sv
source/cdb_mux.sv
source/cdb_core.sv
tests/tb_cdb_core.sv

//--- Makefile
VERILATOR ?= verilator
TOP ?= tb_cdb_core
FILELIST ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
PASS_MSG ?= Simulation completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
